//--- verilog/rv32_isa_pkg.sv
package rv32_isa_pkg;

  // Data path and operand width
  localparam int xlen = 32;

  // Path taken by an issued operation
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MEM = 1'b1
  } unit_e;

  // ALU operations, shifts use operand_b[4:0]
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9
  } alu_op_e;

  // Memory operations
  // Bit 3 store, bit 2 unsigned, bits 1:0 size (byte, half, word)
  typedef enum logic [3:0] {
    MEM_LB  = 4'b0000,
    MEM_LH  = 4'b0001,
    MEM_LW  = 4'b0010,
    MEM_LBU = 4'b0100,
    MEM_LHU = 4'b0101,
    MEM_SB  = 4'b1000,
    MEM_SH  = 4'b1001,
    MEM_SW  = 4'b1010
  } mem_op_e;

endpackage

//--- verilog/rv32_bus_pkg.sv
package rv32_bus_pkg;

  // Word address, byte address bits 31:2
  localparam int adr_width = 30;

  // One select per byte lane of a 32-bit word
  localparam int sel_width = 4;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/100ps

module register_file #(
  parameter int REG_BITS = 5
) (
  input  logic                          clk_i,
  input  logic [REG_BITS-1:0]           rs1_i,
  input  logic [REG_BITS-1:0]           rs2_i,
  input  logic [rv32_isa_pkg::xlen-1:0] imm_i,
  input  logic                          use_imm_i,
  input  logic                          fwd_valid_i,
  input  logic [REG_BITS-1:0]           fwd_rd_i,
  input  logic [rv32_isa_pkg::xlen-1:0] fwd_data_i,
  input  logic                          we_i,
  input  logic [REG_BITS-1:0]           waddr_i,
  input  logic [rv32_isa_pkg::xlen-1:0] wdata_i,
  output logic [rv32_isa_pkg::xlen-1:0] operand_a_o,
  output logic [rv32_isa_pkg::xlen-1:0] operand_b_o,
  output logic [rv32_isa_pkg::xlen-1:0] store_data_o
);
  import rv32_isa_pkg::*;

  logic [xlen-1:0] regs [2**REG_BITS];
  logic [xlen-1:0] rs1_value;
  logic [xlen-1:0] rs2_value;

  // x0 reads zero, otherwise the ALU result register wins over storage
  function automatic logic [xlen-1:0] read_port(input logic [REG_BITS-1:0] addr);
    logic [xlen-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (fwd_valid_i && (fwd_rd_i == addr)) begin
      value = fwd_data_i;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clk_i) begin
    if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  always_comb begin
    rs1_value = read_port(rs1_i);
    rs2_value = read_port(rs2_i);
  end

  assign operand_a_o  = rs1_value;
  assign operand_b_o  = use_imm_i ? imm_i : rs2_value;
  // Stores always take rs2, the immediate goes into the address
  assign store_data_o = rs2_value;

endmodule

//--- verilog/alu_path.sv
`timescale 1ns/100ps

module alu_path #(
  parameter int REG_BITS = 5
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          issue_i,
  input  rv32_isa_pkg::unit_e           unit_i,
  input  rv32_isa_pkg::alu_op_e         alu_op_i,
  input  logic [REG_BITS-1:0]           rd_i,
  input  logic [rv32_isa_pkg::xlen-1:0] operand_a_i,
  input  logic [rv32_isa_pkg::xlen-1:0] operand_b_i,
  output logic                          result_valid_o,
  output logic [REG_BITS-1:0]           result_rd_o,
  output logic [rv32_isa_pkg::xlen-1:0] result_data_o
);
  import rv32_isa_pkg::*;

  logic            alu_issue;
  logic [4:0]      shamt;
  logic            less_signed;
  logic            less_unsigned;
  logic [xlen-1:0] alu_value;

  assign alu_issue     = issue_i && (unit_i == UNIT_ALU);
  assign shamt         = operand_b_i[4:0];
  assign less_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign less_unsigned = operand_a_i < operand_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_value = operand_a_i + operand_b_i;
      ALU_SUB: alu_value = operand_a_i - operand_b_i;
      ALU_AND: alu_value = operand_a_i & operand_b_i;
      ALU_OR:  alu_value = operand_a_i | operand_b_i;
      ALU_XOR: alu_value = operand_a_i ^ operand_b_i;
      ALU_SLL: alu_value = operand_a_i << shamt;
      ALU_SRL: alu_value = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA: alu_value = $signed(operand_a_i) >>> shamt;
      ALU_SLT: begin
        alu_value = {{(xlen-1){1'b0}}, less_signed};
      end
      ALU_SLTU: begin
        alu_value = {{(xlen-1){1'b0}}, less_unsigned};
      end
      default: alu_value = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register, also the forwarding source
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= alu_issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_issue) begin
      result_rd_o   <= rd_i;
      result_data_o <= alu_value;
    end
  end

endmodule

//--- verilog/load_store_path.sv
`timescale 1ns/100ps

module load_store_path #(
  parameter int REG_BITS = 5
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               issue_i,
  input  rv32_isa_pkg::unit_e                unit_i,
  input  rv32_isa_pkg::mem_op_e              mem_op_i,
  input  logic [REG_BITS-1:0]                rd_i,
  input  logic [rv32_isa_pkg::xlen-1:0]      operand_a_i,
  input  logic [rv32_isa_pkg::xlen-1:0]      operand_b_i,
  input  logic [rv32_isa_pkg::xlen-1:0]      store_data_i,
  output logic                               ready_o,
  output logic                               result_valid_o,
  output logic [REG_BITS-1:0]                result_rd_o,
  output logic [rv32_isa_pkg::xlen-1:0]      result_data_o,
  output logic [rv32_bus_pkg::adr_width-1:0] bus_adr_o,
  output logic [rv32_isa_pkg::xlen-1:0]      bus_dat_o,
  input  logic [rv32_isa_pkg::xlen-1:0]      bus_dat_i,
  output logic [rv32_bus_pkg::sel_width-1:0] bus_sel_o,
  output logic                               bus_we_o,
  output logic                               bus_cyc_o,
  output logic                               bus_stb_o,
  input  logic                               bus_ack_i
);
  import rv32_isa_pkg::*;
  import rv32_bus_pkg::*;

  // Idle, bus cycle open, load result on its way to writeback
  typedef enum logic [1:0] {
    LS_IDLE   = 2'd0,
    LS_ACCESS = 2'd1,
    LS_RETIRE = 2'd2
  } ls_state_e;

  ls_state_e            state_q;
  mem_op_e              op_q;
  logic [1:0]           offset_q;
  logic                 accept;
  logic                 load_done;
  logic [xlen-1:0]      eff_addr;
  logic [sel_width-1:0] sel_d;
  logic [xlen-1:0]      wdata_d;
  logic [xlen-1:0]      lane_data;
  logic [xlen-1:0]      load_value;

  assign accept    = issue_i && (unit_i == UNIT_MEM) && (state_q == LS_IDLE);
  assign load_done = (state_q == LS_ACCESS) && bus_ack_i;
  assign eff_addr  = operand_a_i + operand_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Lane steering for the request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (mem_op_i[1:0])
      2'b00: begin
        sel_d   = 4'b0001 << eff_addr[1:0];
        wdata_d = {4{store_data_i[7:0]}};
      end
      2'b01: begin
        sel_d   = 4'b0011 << {eff_addr[1], 1'b0};
        wdata_d = {2{store_data_i[15:0]}};
      end
      default: begin
        sel_d   = 4'b1111;
        wdata_d = store_data_i;
      end
    endcase
  end

  // Request and load payload, held steady for the whole bus cycle
  always_ff @(posedge clk_i) begin
    if (accept) begin
      bus_adr_o   <= eff_addr[adr_width+1:2];
      bus_sel_o   <= sel_d;
      bus_dat_o   <= wdata_d;
      bus_we_o    <= mem_op_i[3];
      op_q        <= mem_op_i;
      offset_q    <= eff_addr[1:0];
      result_rd_o <= rd_i;
    end
    if (load_done) begin
      result_data_o <= load_value;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= LS_IDLE;
    end else begin
      case (state_q)
        LS_IDLE: begin
          if (accept) begin
            state_q <= LS_ACCESS;
          end
        end
        LS_ACCESS: begin
          // Stores finish on the ack, loads still need their writeback cycle
          if (bus_ack_i) begin
            state_q <= op_q[3] ? LS_IDLE : LS_RETIRE;
          end
        end
        default: state_q <= LS_IDLE;
      endcase
    end
  end

  assign ready_o        = (state_q == LS_IDLE);
  assign bus_cyc_o      = (state_q == LS_ACCESS);
  assign bus_stb_o      = (state_q == LS_ACCESS);
  assign result_valid_o = (state_q == LS_RETIRE);

  // Addressed lanes down to bit 0, then extend
  always_comb begin
    lane_data = bus_dat_i >> {offset_q, 3'b000};
    case (op_q)
      MEM_LB:  load_value = {{(xlen-8){lane_data[7]}}, lane_data[7:0]};
      MEM_LBU: load_value = {{(xlen-8){1'b0}}, lane_data[7:0]};
      MEM_LH:  load_value = {{(xlen-16){lane_data[15]}}, lane_data[15:0]};
      MEM_LHU: load_value = {{(xlen-16){1'b0}}, lane_data[15:0]};
      default: load_value = lane_data;
    endcase
  end

endmodule

//--- verilog/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage #(
  parameter int REG_BITS = 5
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          alu_valid_i,
  input  logic [REG_BITS-1:0]           alu_rd_i,
  input  logic [rv32_isa_pkg::xlen-1:0] alu_data_i,
  input  logic                          ld_valid_i,
  input  logic [REG_BITS-1:0]           ld_rd_i,
  input  logic [rv32_isa_pkg::xlen-1:0] ld_data_i,
  output logic                          rf_we_o,
  output logic [REG_BITS-1:0]           rf_waddr_o,
  output logic [rv32_isa_pkg::xlen-1:0] rf_wdata_o,
  output logic                          retire_valid_o,
  output logic [REG_BITS-1:0]           retire_rd_o,
  output logic [rv32_isa_pkg::xlen-1:0] retire_data_o
);
  import rv32_isa_pkg::*;

  logic [REG_BITS-1:0] sel_rd;
  logic [xlen-1:0]     sel_data;

  // Path select, the two valids never overlap
  always_comb begin
    case ({ld_valid_i, alu_valid_i})
      2'b10: begin
        sel_rd   = ld_rd_i;
        sel_data = ld_data_i;
      end
      default: begin
        sel_rd   = alu_rd_i;
        sel_data = alu_data_i;
      end
    endcase
  end

  // No write and no retire for x0
  assign rf_we_o    = (alu_valid_i || ld_valid_i) && (sel_rd != '0);
  assign rf_waddr_o = sel_rd;
  assign rf_wdata_o = sel_data;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= rf_we_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rf_we_o) begin
      retire_rd_o   <= sel_rd;
      retire_data_o <= sel_data;
    end
  end

endmodule

//--- verilog/rv32_backend.sv
`timescale 1ns/100ps

module rv32_backend #(
  parameter int REG_BITS = 5
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  // Issue side
  input  logic                               issue_i,
  input  rv32_isa_pkg::unit_e                unit_i,
  input  rv32_isa_pkg::alu_op_e              alu_op_i,
  input  rv32_isa_pkg::mem_op_e              mem_op_i,
  input  logic [REG_BITS-1:0]                rd_i,
  input  logic [REG_BITS-1:0]                rs1_i,
  input  logic [REG_BITS-1:0]                rs2_i,
  input  logic [rv32_isa_pkg::xlen-1:0]      imm_i,
  input  logic                               use_imm_i,
  output logic                               ready_o,
  // Retire side
  output logic                               retire_valid_o,
  output logic [REG_BITS-1:0]                retire_rd_o,
  output logic [rv32_isa_pkg::xlen-1:0]      retire_data_o,
  // Data bus
  output logic [rv32_bus_pkg::adr_width-1:0] bus_adr_o,
  output logic [rv32_isa_pkg::xlen-1:0]      bus_dat_o,
  input  logic [rv32_isa_pkg::xlen-1:0]      bus_dat_i,
  output logic [rv32_bus_pkg::sel_width-1:0] bus_sel_o,
  output logic                               bus_we_o,
  output logic                               bus_cyc_o,
  output logic                               bus_stb_o,
  input  logic                               bus_ack_i
);
  import rv32_isa_pkg::*;

  logic [xlen-1:0]     operand_a;
  logic [xlen-1:0]     operand_b;
  logic [xlen-1:0]     store_data;

  // ALU result register, also fed back for forwarding
  logic                alu_valid;
  logic [REG_BITS-1:0] alu_rd;
  logic [xlen-1:0]     alu_data;

  logic                ld_valid;
  logic [REG_BITS-1:0] ld_rd;
  logic [xlen-1:0]     ld_data;

  logic                rf_we;
  logic [REG_BITS-1:0] rf_waddr;
  logic [xlen-1:0]     rf_wdata;

  register_file #(
    .REG_BITS     (REG_BITS)
  ) register_file_inst (
    .clk_i        (clk_i),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .imm_i        (imm_i),
    .use_imm_i    (use_imm_i),
    .fwd_valid_i  (alu_valid),
    .fwd_rd_i     (alu_rd),
    .fwd_data_i   (alu_data),
    .we_i         (rf_we),
    .waddr_i      (rf_waddr),
    .wdata_i      (rf_wdata),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .store_data_o (store_data)
  );

  alu_path #(
    .REG_BITS       (REG_BITS)
  ) alu_path_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_i        (issue_i),
    .unit_i         (unit_i),
    .alu_op_i       (alu_op_i),
    .rd_i           (rd_i),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .result_valid_o (alu_valid),
    .result_rd_o    (alu_rd),
    .result_data_o  (alu_data)
  );

  load_store_path #(
    .REG_BITS       (REG_BITS)
  ) load_store_path_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_i        (issue_i),
    .unit_i         (unit_i),
    .mem_op_i       (mem_op_i),
    .rd_i           (rd_i),
    .operand_a_i    (operand_a),
    .operand_b_i    (operand_b),
    .store_data_i   (store_data),
    .ready_o        (ready_o),
    .result_valid_o (ld_valid),
    .result_rd_o    (ld_rd),
    .result_data_o  (ld_data),
    .bus_adr_o      (bus_adr_o),
    .bus_dat_o      (bus_dat_o),
    .bus_dat_i      (bus_dat_i),
    .bus_sel_o      (bus_sel_o),
    .bus_we_o       (bus_we_o),
    .bus_cyc_o      (bus_cyc_o),
    .bus_stb_o      (bus_stb_o),
    .bus_ack_i      (bus_ack_i)
  );

  writeback_stage #(
    .REG_BITS       (REG_BITS)
  ) writeback_stage_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .alu_valid_i    (alu_valid),
    .alu_rd_i       (alu_rd),
    .alu_data_i     (alu_data),
    .ld_valid_i     (ld_valid),
    .ld_rd_i        (ld_rd),
    .ld_data_i      (ld_data),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

//--- test/tb_rv32_backend.sv
`timescale 1ns/100ps

module tb_rv32_backend;
  import rv32_isa_pkg::*;
  import rv32_bus_pkg::*;

  localparam int REG_BITS   = 5;
  localparam int FIELDS     = 9;
  localparam int MAX_OPS    = 64;
  localparam int READY_WAIT = 20;
  localparam int DRAIN_WAIT = 50;

  logic                 clk_i;
  logic                 reset_i;
  logic                 issue_i;
  unit_e                unit_i;
  alu_op_e              alu_op_i;
  mem_op_e              mem_op_i;
  logic [REG_BITS-1:0]  rd_i;
  logic [REG_BITS-1:0]  rs1_i;
  logic [REG_BITS-1:0]  rs2_i;
  logic [xlen-1:0]      imm_i;
  logic                 use_imm_i;
  logic                 ready_o;
  logic                 retire_valid_o;
  logic [REG_BITS-1:0]  retire_rd_o;
  logic [xlen-1:0]      retire_data_o;
  logic [adr_width-1:0] bus_adr_o;
  logic [xlen-1:0]      bus_dat_o;
  logic [xlen-1:0]      bus_dat_i;
  logic [sel_width-1:0] bus_sel_o;
  logic                 bus_we_o;
  logic                 bus_cyc_o;
  logic                 bus_stb_o;
  logic                 bus_ack_i;

  // Nine fields per operation in file order
  logic [31:0]          golden [FIELDS*MAX_OPS];
  logic [xlen-1:0]      bus_mem [256];
  logic [REG_BITS-1:0]  exp_rd_q [$];
  logic [xlen-1:0]      exp_data_q [$];
  int                   exp_cycle_q [$];
  int                   cycle_count = 0;
  int                   load_retire_cycle = -1;

  rv32_backend #(
    .REG_BITS (REG_BITS)
  ) rv32_backend_inst (
    .clk_i, .reset_i, .issue_i, .unit_i, .alu_op_i, .mem_op_i, .rd_i, .rs1_i, .rs2_i,
    .imm_i, .use_imm_i, .ready_o, .retire_valid_o, .retire_rd_o, .retire_data_o,
    .bus_adr_o, .bus_dat_o, .bus_dat_i, .bus_sel_o, .bus_we_o, .bus_cyc_o, .bus_stb_o,
    .bus_ack_i
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #5;
      clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %08h actual %08h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // Retires checked in issue order and on their exact cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (bus_stb_o) begin
        check_value("ready_o", 32'd0, 32'(ready_o));
        check_value("bus_cyc_o", 32'd1, 32'(bus_cyc_o));
      end
      if (retire_valid_o) begin
        if (exp_rd_q.size() == 0) begin
          $display("Register %0d retired at %0t with no retire pending", retire_rd_o, $time);
          abort_run();
        end else begin
          check_value("retire_rd_o", 32'(exp_rd_q[0]), 32'(retire_rd_o));
          check_value("retire_data_o", exp_data_q[0], retire_data_o);
          if (exp_cycle_q[0] >= 0) begin
            check_value("retire cycle", exp_cycle_q[0], cycle_count);
          end else begin
            // Loaded value already in the register file
            check_value("load retire cycle", load_retire_cycle, cycle_count);
            check_value("ready_o", 32'd1, 32'(ready_o));
          end
          void'(exp_rd_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_cycle_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus slave memory
  ////////////////////////////////////////////////////////////////////////////

  initial begin : bus_slave
    int          i;
    int          delay;
    logic [31:0] lane_mask;
    void'($urandom(32'h7a51_8786));
    bus_ack_i = 1'b0;
    bus_dat_i = '0;
    for (i = 0; i < 256; i++) begin
      bus_mem[i] = '0;
    end
    forever begin
      @(posedge clk_i);
      #1;
      if (bus_cyc_o && bus_stb_o) begin
        delay = $urandom_range(3, 0);
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        lane_mask = {{8{bus_sel_o[3]}}, {8{bus_sel_o[2]}}, {8{bus_sel_o[1]}},
                     {8{bus_sel_o[0]}}};
        if (bus_we_o) begin
          bus_mem[bus_adr_o[7:0]] = (bus_mem[bus_adr_o[7:0]] & ~lane_mask) |
                                    (bus_dat_o & lane_mask);
        end else begin
          bus_dat_i = bus_mem[bus_adr_o[7:0]];
          // Ack sampled at the next edge, retire one edge later
          load_retire_cycle = cycle_count + 2;
        end
        bus_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        bus_ack_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!ready_o && (cycles < READY_WAIT)) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!ready_o) begin
      $display("Timeout at %0t, ready_o stayed low for %0d cycles", $time, READY_WAIT);
      abort_run();
    end
  endtask

  // Runs from 1 ns after a rising edge to 1 ns after the issue edge
  task automatic issue_op(input int idx);
    int base;
    base = idx * FIELDS;
    wait_ready();
    issue_i   = 1'b1;
    unit_i    = unit_e'(golden[base][0]);
    alu_op_i  = alu_op_e'(golden[base+1][3:0]);
    mem_op_i  = mem_op_e'(golden[base+1][3:0]);
    rd_i      = golden[base+2][REG_BITS-1:0];
    rs1_i     = golden[base+3][REG_BITS-1:0];
    rs2_i     = golden[base+4][REG_BITS-1:0];
    imm_i     = golden[base+5];
    use_imm_i = golden[base+6][0];
    if (golden[base+7][0]) begin
      exp_rd_q.push_back(golden[base+2][REG_BITS-1:0]);
      exp_data_q.push_back(golden[base+8]);
      // ALU ops retire two edges after issue
      // Loads are timed from the ack instead
      if (unit_i == UNIT_MEM) begin
        exp_cycle_q.push_back(-1);
      end else begin
        exp_cycle_q.push_back(cycle_count + 2);
      end
    end
    @(posedge clk_i);
    #1;
    issue_i = 1'b0;
  endtask

  task automatic drain_retires();
    int cycles;
    cycles = 0;
    while ((exp_rd_q.size() != 0) && (cycles < DRAIN_WAIT)) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (exp_rd_q.size() != 0) begin
      $display("Timeout at %0t, %0d retires never arrived", $time, exp_rd_q.size());
      abort_run();
    end
  endtask

  initial begin : main_flow
    int op_idx;
    reset_i   = 1'b1;
    issue_i   = 1'b0;
    unit_i    = UNIT_ALU;
    alu_op_i  = ALU_ADD;
    mem_op_i  = MEM_LW;
    rd_i      = '0;
    rs1_i     = '0;
    rs2_i     = '0;
    imm_i     = '0;
    use_imm_i = 1'b0;
    $readmemh("test/backend_golden.mem", golden);
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_value("retire_valid_o", 32'd0, 32'(retire_valid_o));
    check_value("bus_stb_o", 32'd0, 32'(bus_stb_o));
    check_value("bus_cyc_o", 32'd0, 32'(bus_cyc_o));
    check_value("ready_o", 32'd1, 32'(ready_o));
    op_idx = 0;
    while ((op_idx < MAX_OPS) && (golden[op_idx*FIELDS] != 32'hf)) begin
      issue_op(op_idx);
      op_idx++;
    end
    drain_retires();
    // A few idle cycles to catch a stray retire
    repeat (3) @(posedge clk_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- build.f
verilog/rv32_isa_pkg.sv
verilog/rv32_bus_pkg.sv
verilog/register_file.sv
verilog/alu_path.sv
verilog/load_store_path.sv
verilog/writeback_stage.sv
verilog/rv32_backend.sv
test/tb_rv32_backend.sv

//--- Makefile
# Verilator build and run for the execute/writeback back end

VERILATOR ?= verilator
TOP       ?= tb_rv32_backend
FILE_LIST ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
GOLDEN    ?= test/backend_golden.mem
VFLAGS    ?= --binary -j 0 --timescale 1ns/100ps
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILE_LIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM) $(GOLDEN)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/backend_golden.mem
// Columns unit op rd rs1 rs2 imm use_imm retire_expected retire_value
// Unit 0 is the ALU and 1 the memory path, unit f ends the list
// Registers from immediates
0 0 01 00 00 12345678 1 1 12345678
0 0 02 00 00 fffffff0 1 1 fffffff0
0 0 03 00 00 00000005 1 1 00000005
// Dependent chain through the result register
0 0 04 03 01 00000000 0 1 1234567d
0 1 05 04 03 00000000 0 1 12345678
0 2 06 01 00 0ff00ff0 1 1 02300670
0 3 07 06 03 00000000 0 1 02300675
0 4 08 07 01 00000000 0 1 1004500d
// Shifts and compares
0 5 09 03 00 00000024 1 1 00000050
0 6 0a 02 00 00000004 1 1 0fffffff
0 7 0b 02 00 00000002 1 1 fffffffc
0 8 0c 02 03 00000000 0 1 00000001
0 9 0d 02 03 00000000 0 1 00000000
0 9 0e 03 02 00000000 0 1 00000001
// x0 as destination then as source
0 0 00 01 00 00000100 1 0 00000000
0 0 0f 00 01 00000000 0 1 12345678
// Stores and loads over the bus
1 a 00 00 01 00000040 1 0 00000000
1 2 10 00 00 00000040 1 1 12345678
1 0 11 00 00 00000041 1 1 00000056
1 8 00 00 02 00000043 1 0 00000000
1 0 12 00 00 00000043 1 1 fffffff0
1 4 13 00 00 00000043 1 1 000000f0
1 9 00 00 02 00000046 1 0 00000000
1 1 14 00 00 00000046 1 1 fffffff0
1 5 15 00 00 00000046 1 1 0000fff0
1 1 16 00 00 00000040 1 1 00005678
1 2 17 00 00 00000044 1 1 fff00000
0 0 18 17 00 00000001 1 1 fff00001
1 5 19 00 00 00000042 1 1 0000f034
0 0 1a 19 18 00000000 0 1 fff0f035
1 a 00 03 08 0000004b 1 0 00000000
1 4 1b 03 00 0000004e 1 1 00000010
1 2 00 00 00 00000050 1 0 00000000
0 1 1c 00 03 00000000 0 1 fffffffb
f 0 00 00 00 00000000 0 0 00000000
